// File: common/cpu_pkg.sv
// shared encodings for the 8-bit core and opcodes 12 to 15 are left unassigned so they run as NOP
package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int DATA_W    = 8;
  localparam int ADDR_W    = 4;
  localparam int MEM_DEPTH = 16;
  localparam int OPC_W     = 4;
  localparam int REG_SEL_W = 2;
  localparam int SRC_W     = 2;
  localparam int ALU_W     = 2;

  ////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [OPC_W-1:0] OP_NOP    = 4'd0;
  localparam logic [OPC_W-1:0] OP_LDA_LO = 4'd1;
  localparam logic [OPC_W-1:0] OP_LDA_HI = 4'd2;
  localparam logic [OPC_W-1:0] OP_LDB_LO = 4'd3;
  localparam logic [OPC_W-1:0] OP_LDB_HI = 4'd4;
  localparam logic [OPC_W-1:0] OP_LDC_LO = 4'd5;
  localparam logic [OPC_W-1:0] OP_LDC_HI = 4'd6;
  localparam logic [OPC_W-1:0] OP_ADD    = 4'd7;
  localparam logic [OPC_W-1:0] OP_SUB    = 4'd8;
  localparam logic [OPC_W-1:0] OP_MUL    = 4'd9;
  localparam logic [OPC_W-1:0] OP_OUT    = 4'd10;
  localparam logic [OPC_W-1:0] OP_IN     = 4'd11;

  // register selects, code 3 has no register behind it
  localparam logic [REG_SEL_W-1:0] REG_A = 2'd0;
  localparam logic [REG_SEL_W-1:0] REG_B = 2'd1;
  localparam logic [REG_SEL_W-1:0] REG_C = 2'd2;

  // write-back sources
  localparam logic [SRC_W-1:0] SRC_IMM_LO = 2'd0;
  localparam logic [SRC_W-1:0] SRC_IMM_HI = 2'd1;
  localparam logic [SRC_W-1:0] SRC_INPUT  = 2'd2;
  localparam logic [SRC_W-1:0] SRC_ALU    = 2'd3;

  localparam logic [ALU_W-1:0] ALU_ADD = 2'd0;
  localparam logic [ALU_W-1:0] ALU_SUB = 2'd1;
  localparam logic [ALU_W-1:0] ALU_MUL = 2'd2;

  ////////////////////////////////////////////////////////////
  // uio_in pin map
  ////////////////////////////////////////////////////////////

  localparam int PIN_RUN     = 7;
  localparam int PIN_MODE_HI = 5;
  localparam int PIN_MODE_LO = 4;

  localparam logic [1:0] MODE_LOAD = 2'b01;

  // one instruction byte, loads read the nibble and IN/OUT read the select
  typedef union packed {
    struct packed {
      logic [OPC_W-1:0] opc;
      logic [3:0]       imm;
    } imm_view;
    struct packed {
      logic [OPC_W-1:0]     opc;
      logic [1:0]           pad;
      logic [REG_SEL_W-1:0] sel;
    } sel_view;
  } instr_u;

endpackage

// File: compile.f
common/cpu_pkg.sv
src/prog_mem.sv
core/sequencer.sv
core/datapath.sv
src/tiny_cpu_top.sv
tb/tiny_cpu_tb.sv

// File: core/datapath.sv
// registers A, B, C and uo_out with ALU results modulo 256 and select 3 reading as zero
`timescale 1ns/1ps

module datapath (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cpu_pkg::DATA_W-1:0]    in_data,
  input  logic                          wr_en,
  input  logic [cpu_pkg::REG_SEL_W-1:0] wr_sel,
  input  logic [cpu_pkg::SRC_W-1:0]     wr_src,
  input  logic [3:0]                    imm,
  input  logic [cpu_pkg::ALU_W-1:0]     alu_op,
  input  logic                          out_en,
  input  logic [cpu_pkg::REG_SEL_W-1:0] out_sel,
  output logic [cpu_pkg::DATA_W-1:0]    out_data
);

  logic [cpu_pkg::DATA_W-1:0]   a_q;
  logic [cpu_pkg::DATA_W-1:0]   b_q;
  logic [cpu_pkg::DATA_W-1:0]   c_q;
  logic [cpu_pkg::DATA_W-1:0]   alu_res;
  logic [cpu_pkg::DATA_W-1:0]   wr_cur;
  logic [cpu_pkg::DATA_W-1:0]   wr_data;
  logic [cpu_pkg::DATA_W-1:0]   out_val;

  // register read mux, shared by the write-back and output paths
  function automatic logic [cpu_pkg::DATA_W-1:0] pick_reg(
    input logic [cpu_pkg::REG_SEL_W-1:0] sel,
    input logic [cpu_pkg::DATA_W-1:0]    a,
    input logic [cpu_pkg::DATA_W-1:0]    b,
    input logic [cpu_pkg::DATA_W-1:0]    c
  );
    case (sel)
      cpu_pkg::REG_A: pick_reg = a;
      cpu_pkg::REG_B: pick_reg = b;
      cpu_pkg::REG_C: pick_reg = c;
      default:        pick_reg = '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////

  // the product wraps to its low byte
  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_ADD: alu_res = a_q + b_q;
      cpu_pkg::ALU_SUB: alu_res = a_q - b_q;
      cpu_pkg::ALU_MUL: alu_res = a_q * b_q;
      default:          alu_res = a_q + b_q;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // write-back
  ////////////////////////////////////////////////////////////

  assign wr_cur = pick_reg(wr_sel, a_q, b_q, c_q);

  // nibble loads keep the other half of the target
  always_comb begin
    case (wr_src)
      cpu_pkg::SRC_IMM_LO: wr_data = {wr_cur[7:4], imm};
      cpu_pkg::SRC_IMM_HI: wr_data = {imm, wr_cur[3:0]};
      cpu_pkg::SRC_INPUT:  wr_data = in_data;
      default:             wr_data = alu_res;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
      b_q <= '0;
      c_q <= '0;
    end else if (wr_en) begin
      case (wr_sel)
        cpu_pkg::REG_A: a_q <= wr_data;
        cpu_pkg::REG_B: b_q <= wr_data;
        cpu_pkg::REG_C: c_q <= wr_data;
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  assign out_val = pick_reg(out_sel, a_q, b_q, c_q);

  // takes the value from before the edge, so OUT after a write sees the old C only
  // when both sit in the same cycle, which the sequencer never issues
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_data <= '0;
    end else if (out_en) begin
      out_data <= out_val;
    end
  end

  a_out_only_on_out: assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(out_data) |-> $past(out_en)
  ) else $error("uo_out changed without an OUT instruction");

endmodule

// File: core/sequencer.sv
// one instruction per cycle while run is high and no load is under way, selects of 3 and opcodes 12-15 do nothing
`timescale 1ns/1ps

module sequencer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          run,
  input  logic                          load_active,
  input  cpu_pkg::instr_u               instr,
  output logic [cpu_pkg::ADDR_W-1:0]    pc,
  output logic                          wr_en,
  output logic [cpu_pkg::REG_SEL_W-1:0] wr_sel,
  output logic [cpu_pkg::SRC_W-1:0]     wr_src,
  output logic [3:0]                    imm,
  output logic [cpu_pkg::ALU_W-1:0]     alu_op,
  output logic                          out_en,
  output logic [cpu_pkg::REG_SEL_W-1:0] out_sel
);

  logic exec;
  logic sel_ok;
  logic dec_wr;
  logic dec_out;

  // loading wins over running
  assign exec = run && !load_active;

  ////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////

  // wraps from 15 back to 0 on its own
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (exec) begin
      pc <= pc + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  assign sel_ok  = (instr.sel_view.sel <= cpu_pkg::REG_C);
  assign imm     = instr.imm_view.imm;
  assign out_sel = instr.sel_view.sel;

  always_comb begin
    dec_wr  = 1'b0;
    dec_out = 1'b0;
    wr_sel  = cpu_pkg::REG_A;
    wr_src  = cpu_pkg::SRC_IMM_LO;
    alu_op  = cpu_pkg::ALU_ADD;
    case (instr.imm_view.opc)
      cpu_pkg::OP_NOP: begin
      end
      cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDB_LO, cpu_pkg::OP_LDC_LO: begin
        dec_wr = 1'b1;
        wr_src = cpu_pkg::SRC_IMM_LO;
        if (instr.imm_view.opc == cpu_pkg::OP_LDB_LO) wr_sel = cpu_pkg::REG_B;
        if (instr.imm_view.opc == cpu_pkg::OP_LDC_LO) wr_sel = cpu_pkg::REG_C;
      end
      cpu_pkg::OP_LDA_HI, cpu_pkg::OP_LDB_HI, cpu_pkg::OP_LDC_HI: begin
        dec_wr = 1'b1;
        wr_src = cpu_pkg::SRC_IMM_HI;
        if (instr.imm_view.opc == cpu_pkg::OP_LDB_HI) wr_sel = cpu_pkg::REG_B;
        if (instr.imm_view.opc == cpu_pkg::OP_LDC_HI) wr_sel = cpu_pkg::REG_C;
      end
      cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL: begin
        // all ALU results land in C
        dec_wr = 1'b1;
        wr_sel = cpu_pkg::REG_C;
        wr_src = cpu_pkg::SRC_ALU;
        if (instr.imm_view.opc == cpu_pkg::OP_SUB) alu_op = cpu_pkg::ALU_SUB;
        if (instr.imm_view.opc == cpu_pkg::OP_MUL) alu_op = cpu_pkg::ALU_MUL;
      end
      cpu_pkg::OP_IN: begin
        dec_wr = sel_ok;
        wr_sel = instr.sel_view.sel;
        wr_src = cpu_pkg::SRC_INPUT;
      end
      cpu_pkg::OP_OUT: begin
        dec_out = sel_ok;
      end
      default: begin
        // 12..15 are spare
      end
    endcase
  end

  assign wr_en  = exec && dec_wr;
  assign out_en = exec && dec_out;

  a_one_port: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(wr_en && out_en)
  ) else $error("register write and output write in the same cycle");

  a_pc_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    !exec |=> $stable(pc)
  ) else $error("pc moved in a cycle that did not execute");

endmodule

// File: src/prog_mem.sv
// bytes load only while mode is 01 and the byte at pc is read without a clock, so a new byte shows a cycle later
`timescale 1ns/1ps

module prog_mem (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [cpu_pkg::DATA_W-1:0] ui_in,
  input  logic [1:0]                 mode,
  input  logic [cpu_pkg::ADDR_W-1:0] load_addr,
  input  logic [cpu_pkg::ADDR_W-1:0] pc,
  output logic                       load_active,
  output cpu_pkg::instr_u            instr
);

  logic [cpu_pkg::DATA_W-1:0] mem [cpu_pkg::MEM_DEPTH];

  ////////////////////////////////////////////////////////////
  // load decode
  ////////////////////////////////////////////////////////////

  // only mode 01 writes, the other mode codes leave the memory alone
  assign load_active = (mode == cpu_pkg::MODE_LOAD);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // memory comes up all zero, which is a page of NOPs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < cpu_pkg::MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (load_active) begin
      mem[load_addr] <= ui_in;
    end
  end

  // read port
  assign instr = mem[pc];

  // a write to an unknown address would smear the whole program
  a_load_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    load_active |-> !$isunknown(load_addr)
  ) else $error("program load with unknown address %b", load_addr);

endmodule

// File: src/tiny_cpu_top.sv
// pin frame for the 8-bit core, uio pins are inputs only and ena is not used since it is always high when powered
`timescale 1ns/1ps

module tiny_cpu_top (
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n
);

  logic                          run;
  logic [1:0]                    mode;
  logic [cpu_pkg::ADDR_W-1:0]    load_addr;
  logic                          load_active;
  cpu_pkg::instr_u               instr;
  logic [cpu_pkg::ADDR_W-1:0]    pc;
  logic                          wr_en;
  logic [cpu_pkg::REG_SEL_W-1:0] wr_sel;
  logic [cpu_pkg::SRC_W-1:0]     wr_src;
  logic [3:0]                    imm;
  logic [cpu_pkg::ALU_W-1:0]     alu_op;
  logic                          out_en;
  logic [cpu_pkg::REG_SEL_W-1:0] out_sel;

  ////////////////////////////////////////////////////////////
  // pin split
  ////////////////////////////////////////////////////////////

  // bit 6 is spare
  assign run       = uio_in[cpu_pkg::PIN_RUN];
  assign mode      = uio_in[cpu_pkg::PIN_MODE_HI:cpu_pkg::PIN_MODE_LO];
  assign load_addr = uio_in[cpu_pkg::ADDR_W-1:0];

  assign uio_out = '0;
  assign uio_oe  = '0;

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  prog_mem u_prog_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .ui_in       (ui_in),
    .mode        (mode),
    .load_addr   (load_addr),
    .pc          (pc),
    .load_active (load_active),
    .instr       (instr)
  );

  sequencer u_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .load_active (load_active),
    .instr       (instr),
    .pc          (pc),
    .wr_en       (wr_en),
    .wr_sel      (wr_sel),
    .wr_src      (wr_src),
    .imm         (imm),
    .alu_op      (alu_op),
    .out_en      (out_en),
    .out_sel     (out_sel)
  );

  // IN reads the same ui_in pins that carry load data
  datapath u_datapath (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (ui_in),
    .wr_en    (wr_en),
    .wr_sel   (wr_sel),
    .wr_src   (wr_src),
    .imm      (imm),
    .alu_op   (alu_op),
    .out_en   (out_en),
    .out_sel  (out_sel),
    .out_data (uo_out)
  );

endmodule

// File: tb/tiny_cpu_tb.sv
// every test program starts at pc 0 and, apart from the wrap test, runs exactly 16 instructions
`timescale 1ns/1ps

module tiny_cpu_tb;

  // 10 reset cycles plus six tests of about 16 load and 20 run cycles, with margin
  localparam int CYCLE_LIMIT = 400;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [7:0]  ui_in;
  logic [7:0]  uio_in;
  logic        ena;
  logic [7:0]  uo_out;
  logic [7:0]  uio_out;
  logic [7:0]  uio_oe;

  logic        check;
  logic        hold;
  logic [7:0]  exp_val;
  logic [16:0] lfsr;
  logic [7:0]  prog [16];
  logic [7:0]  in_at [16];
  logic [7:0]  out_exp [16];
  logic        out_chk [16];
  // expected contents of A, B and C, carried from test to test
  logic [7:0]  ra;
  logic [7:0]  rb;
  logic [7:0]  rc;
  string       test_name;
  int          cycles;
  int          errors;
  int          checks;
  int          tests;
  int          failed;
  int          test_err;

  tiny_cpu_top uut (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // checkers
  ////////////////////////////////////////////////////////////

  a_out_value: assert property (@(posedge clk) disable iff (!rst_n) check |-> uo_out == exp_val)
    else begin
      errors++;
      $display("mismatch %s expected %02h actual %02h", test_name, $sampled(exp_val),
               $sampled(uo_out));
    end

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n) hold |-> $stable(uo_out))
    else begin
      errors++;
      $display("uo_out changed while run was low in test %s", test_name);
    end

  a_uio_zero: assert property (@(posedge clk) uio_out == 8'h00 && uio_oe == 8'h00)
    else begin
      errors++;
      $display("uio_out or uio_oe is not tied to zero in test %s", test_name);
    end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // 17-bit Fibonacci register, taps 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] imm_instr(input logic [3:0] opc, input logic [3:0] nib);
    cpu_pkg::instr_u w;
    w.imm_view.opc = opc;
    w.imm_view.imm = nib;
    return w;
  endfunction

  function automatic logic [7:0] sel_instr(input logic [3:0] opc, input logic [1:0] sel);
    cpu_pkg::instr_u w;
    w = '0;
    w.sel_view.opc = opc;
    w.sel_view.sel = sel;
    return w;
  endfunction

  task automatic place_out(input int addr, input logic [1:0] sel, input logic [7:0] val);
    prog[addr]    = sel_instr(cpu_pkg::OP_OUT, sel);
    out_chk[addr] = 1'b1;
    out_exp[addr] = val;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err  = errors;
    for (int k = 0; k < 16; k++) begin
      prog[k]    = '0;
      in_at[k]   = '0;
      out_exp[k] = '0;
      out_chk[k] = 1'b0;
    end
  endtask

  task automatic end_test();
    @(negedge clk);
    tests++;
    if (errors != test_err) failed++;
    $display("test %s: %s (%0d errors)", test_name, (errors == test_err) ? "pass" : "fail",
             errors - test_err);
  endtask

  // one byte per cycle in mode 01 with run low
  task automatic load_program();
    @(posedge clk);
    for (int k = 0; k < 16; k++) begin
      uio_in <= {2'b00, cpu_pkg::MODE_LOAD, k[3:0]};
      ui_in  <= prog[k];
      @(posedge clk);
    end
  endtask

  // check goes high for the cycle after each OUT edge
  // hold stays up until the first edge after run returns
  task automatic run_program(input int n_exec, input int pause_at, input int pause_len);
    int addr;
    addr = 0;
    for (int i = 0; i < n_exec; i++) begin
      uio_in <= 8'h80;
      ui_in  <= in_at[addr];
      @(posedge clk);
      check   <= out_chk[addr];
      exp_val <= out_exp[addr];
      hold    <= 1'b0;
      if (out_chk[addr]) checks++;
      addr = (addr + 1) % 16;
      if (i == pause_at) begin
        uio_in <= 8'h00;
        repeat (pause_len) begin
          @(posedge clk);
          check <= 1'b0;
          hold  <= 1'b1;
        end
      end
    end
    uio_in <= 8'h00;
    @(posedge clk);
    check <= 1'b0;
    hold  <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [7:0] n0;
    logic [7:0] n1;
    logic [7:0] v;
    rst_n   = 1'b0;
    ui_in   = '0;
    uio_in  = '0;
    ena     = 1'b1;
    check   = 1'b0;
    hold    = 1'b0;
    exp_val = '0;
    lfsr    = 17'd95187;
    cycles  = 0;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    failed  = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset");
    ra = '0;
    rb = '0;
    rc = '0;
    @(posedge clk);
    check   <= 1'b1;
    exp_val <= 8'h00;
    checks++;
    @(posedge clk);
    check <= 1'b0;
    end_test();

    start_test("nibble_load");
    rand_bits(4, n0);
    rand_bits(4, n1);
    prog[0] = imm_instr(cpu_pkg::OP_LDA_LO, n0[3:0]);
    prog[1] = imm_instr(cpu_pkg::OP_LDA_HI, n1[3:0]);
    ra = {n1[3:0], n0[3:0]};
    place_out(2, cpu_pkg::REG_A, ra);
    load_program();
    run_program(16, -1, 0);
    end_test();

    start_test("alu");
    rand_bits(8, ra);
    rand_bits(8, rb);
    prog[0] = imm_instr(cpu_pkg::OP_LDA_LO, ra[3:0]);
    prog[1] = imm_instr(cpu_pkg::OP_LDA_HI, ra[7:4]);
    prog[2] = imm_instr(cpu_pkg::OP_LDB_LO, rb[3:0]);
    prog[3] = imm_instr(cpu_pkg::OP_LDB_HI, rb[7:4]);
    prog[4] = imm_instr(cpu_pkg::OP_ADD, 4'h0);
    place_out(5, cpu_pkg::REG_C, ra + rb);
    prog[6] = imm_instr(cpu_pkg::OP_SUB, 4'h0);
    place_out(7, cpu_pkg::REG_C, ra - rb);
    prog[8] = imm_instr(cpu_pkg::OP_MUL, 4'h0);
    // an 8-bit result keeps the low byte of the product
    rc = ra * rb;
    place_out(9, cpu_pkg::REG_C, rc);
    load_program();
    run_program(16, -1, 0);
    end_test();

    start_test("in_select");
    rand_bits(8, ra);
    rand_bits(8, rb);
    rand_bits(8, rc);
    rand_bits(8, v);
    prog[0]  = sel_instr(cpu_pkg::OP_IN, cpu_pkg::REG_A);
    in_at[0] = ra;
    prog[1]  = sel_instr(cpu_pkg::OP_IN, cpu_pkg::REG_B);
    in_at[1] = rb;
    prog[2]  = sel_instr(cpu_pkg::OP_IN, cpu_pkg::REG_C);
    in_at[2] = rc;
    // select 3 must not land anywhere
    prog[3]  = sel_instr(cpu_pkg::OP_IN, 2'd3);
    in_at[3] = v;
    place_out(4, cpu_pkg::REG_A, ra);
    place_out(5, cpu_pkg::REG_B, rb);
    place_out(6, cpu_pkg::REG_C, rc);
    load_program();
    run_program(16, -1, 0);
    end_test();

    start_test("run_pin");
    rand_bits(8, v);
    rand_bits(8, rb);
    prog[0] = imm_instr(cpu_pkg::OP_LDC_LO, v[3:0]);
    prog[1] = imm_instr(cpu_pkg::OP_LDC_HI, v[7:4]);
    place_out(2, cpu_pkg::REG_C, v);
    prog[3] = imm_instr(cpu_pkg::OP_LDB_LO, rb[3:0]);
    prog[4] = imm_instr(cpu_pkg::OP_LDB_HI, rb[7:4]);
    place_out(5, cpu_pkg::REG_B, rb);
    prog[6] = imm_instr(cpu_pkg::OP_ADD, 4'h0);
    rc = ra + rb;
    place_out(7, cpu_pkg::REG_C, rc);
    load_program();
    run_program(16, 2, 6);
    end_test();

    start_test("nop_wrap");
    place_out(0, cpu_pkg::REG_A, ra);
    place_out(6, cpu_pkg::REG_B, rb);
    place_out(7, cpu_pkg::REG_C, rc);
    // spare opcodes and plain NOPs elsewhere, with noise on ui_in
    for (int k = 1; k < 16; k++) begin
      rand_bits(8, v);
      in_at[k] = v;
      if (k != 6 && k != 7) begin
        prog[k] = (k % 5 == 0) ? 8'h00 : imm_instr(4'd12 + k[1:0], v[3:0]);
      end
    end
    load_program();
    run_program(17, -1, 0);
    end_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks,
             errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
